// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_csr_unit
FILELIST   = src.f
LOG        = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST) $(shell cat $(FILELIST)) csr_vectors.mem
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// File: csr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module csr_decode (
  input  wire                           csr_write,
  input  wire [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  wire [csr_pkg::CSR_ADDR_W-1:0] csr_achk,
  output logic                          mstatus_wr,
  output logic                          mie_wr,
  output logic                          mtvec_wr,
  output logic                          mscratch_wr,
  output logic                          mcinh_wr,
  output logic                          mcycle_wr,
  output logic                          mcycleh_wr,
  output logic                          minstret_wr,
  output logic                          minstreth_wr,
  output logic                          csr_ok_int
);
  import csr_pkg::*;

  // Write strobes, machine names only
  assign mstatus_wr   = csr_write && (csr_addr == CSR_MSTATUS);
  assign mie_wr       = csr_write && (csr_addr == CSR_MIE);
  assign mtvec_wr     = csr_write && (csr_addr == CSR_MTVEC);
  assign mscratch_wr  = csr_write && (csr_addr == CSR_MSCRATCH);
  assign mcinh_wr     = csr_write && (csr_addr == CSR_MCOUNTINHIBIT);
  assign mcycle_wr    = csr_write && (csr_addr == CSR_MCYCLE);
  assign mcycleh_wr   = csr_write && (csr_addr == CSR_MCYCLEH);
  assign minstret_wr  = csr_write && (csr_addr == CSR_MINSTRET);
  assign minstreth_wr = csr_write && (csr_addr == CSR_MINSTRETH);

  always_comb begin                                       // Implemented register list
    case (csr_achk)
      CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
      CSR_MSCRATCH, CSR_MIP, CSR_MCOUNTINHIBIT,
      CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH,
      CSR_CYCLE, CSR_CYCLEH, CSR_INSTRET, CSR_INSTRETH,
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
      CSR_MHARTID:  csr_ok_int = 1'b1;
      default:      csr_ok_int = 1'b0;                    // Debug, time, trap regs too
    endcase
  end

endmodule

`default_nettype wire

// File: csr_event_counter.sv
`timescale 1ns/1ps
`default_nettype none

module csr_event_counter (
  input  wire                        clk,
  input  wire                        resetb,
  input  wire                        count_en,
  input  wire                        wr_lo,
  input  wire                        wr_hi,
  input  wire csr_pkg::csr_word_u    wdata,
  output logic [2*csr_pkg::XLEN-1:0] count
);
  import csr_pkg::*;

  logic [XLEN-1:0] lo_reg;                                // Low half
  logic [XLEN-1:0] hi_reg;                                // High half
  logic            lo_full;                               // Carry out of low half

  assign lo_full = &lo_reg;

  always_ff @(posedge clk or negedge resetb) begin
    if (!resetb)       lo_reg <= '0;
    else if (wr_lo)    lo_reg <= wdata.raw;               // Software load wins
    else if (count_en) lo_reg <= lo_reg + 1'b1;           // Wraps to 0
  end

  always_ff @(posedge clk or negedge resetb) begin
    if (!resetb)                   hi_reg <= '0;
    else if (wr_hi)                hi_reg <= wdata.raw;
    else if (count_en && lo_full)  hi_reg <= hi_reg + 1'b1;  // Uses old low half
  end

  assign count = {hi_reg, lo_reg};

  // One CSR address per cycle, so halves never load together
  half_wr_excl: assert property (@(posedge clk) disable iff (!resetb)
                                 !(wr_lo && wr_hi));

endmodule

`default_nettype wire

// File: csr_machine_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_machine_regs (
  input  wire                    clk,
  input  wire                    resetb,
  input  wire                    mstatus_wr,
  input  wire                    mie_wr,
  input  wire                    mtvec_wr,
  input  wire                    mscratch_wr,
  input  wire                    mcinh_wr,
  input  wire                    iack_int,
  input  wire                    eret_inst,
  input  wire csr_pkg::csr_word_u wdata,
  output logic                   mie_reg,
  output logic                   mpie_reg,
  output logic                   meie_reg,
  output logic                   mtie_reg,
  output logic                   msie_reg,
  output logic [csr_pkg::MLI_W-1:0]  mlie_reg,
  output logic [csr_pkg::XLEN-3:0]   mtvec_reg,
  output logic [1:0]                 vmode_reg,
  output logic [csr_pkg::XLEN-1:0]   mscratch_reg,
  output logic                   cycle_inhibit,
  output logic                   instret_inhibit
);
  import csr_pkg::*;

  // Interrupt enable stack, write > iack > eret
  always_ff @(posedge clk or negedge resetb) begin
    if (!resetb) begin
      mie_reg  <= 1'b0;
      mpie_reg <= 1'b1;                                   // Previous enable set
    end else if (mstatus_wr) begin
      mie_reg  <= wdata.mstatus.mie;
      mpie_reg <= wdata.mstatus.mpie;
    end else if (iack_int) begin                          // Push on trap entry
      mie_reg  <= 1'b0;
      mpie_reg <= mie_reg;
    end else if (eret_inst) begin                         // Pop on return
      mie_reg  <= mpie_reg;
      mpie_reg <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge resetb) begin
    if (!resetb) begin
      mlie_reg        <= '0;
      meie_reg        <= 1'b0;
      mtie_reg        <= 1'b0;
      msie_reg        <= 1'b0;
      mtvec_reg       <= MTVEC_RST;
      vmode_reg       <= 2'b00;
      mscratch_reg    <= MSCRATCH_RST;
      cycle_inhibit   <= 1'b0;                            // Counters run from reset
      instret_inhibit <= 1'b0;
    end else begin
      if (mie_wr) begin
        mlie_reg <= wdata.mie.mlie;
        meie_reg <= wdata.mie.meie;
        mtie_reg <= wdata.mie.mtie;
        msie_reg <= wdata.mie.msie;
      end
      if (mtvec_wr) begin
        mtvec_reg <= wdata.mtvec.base;
        vmode_reg <= wdata.mtvec.mode;
      end
      if (mscratch_wr) mscratch_reg <= wdata.raw;
      if (mcinh_wr) begin
        cycle_inhibit   <= wdata.mcinh.cy;
        instret_inhibit <= wdata.mcinh.ir;
      end
    end
  end

  // Trap entry and return come from different pipeline stages
  iack_eret_excl: assert property (@(posedge clk) disable iff (!resetb)
                                   !(iack_int && eret_inst));

endmodule

`default_nettype wire

// File: csr_pkg.sv
`default_nettype none

package csr_pkg;

  localparam int CSR_ADDR_W = 12;                         // CSR address width
  localparam int XLEN       = 32;                         // Data word width
  localparam int MLI_W      = 16;                         // Local interrupt lines
  localparam int HW_ID_W    = 10;                         // Hart id width

  // Machine information and trap setup
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS       = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MISA          = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE           = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC         = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCOUNTINHIBIT = 12'h320;
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH      = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIP           = 12'h344;
  // Machine counters, read/write
  localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE        = 12'hB00;
  localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET      = 12'hB02;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH       = 12'hB80;
  localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRETH     = 12'hB82;
  // User aliases, read only
  localparam logic [CSR_ADDR_W-1:0] CSR_CYCLE         = 12'hC00;
  localparam logic [CSR_ADDR_W-1:0] CSR_INSTRET       = 12'hC02;
  localparam logic [CSR_ADDR_W-1:0] CSR_CYCLEH        = 12'hC80;
  localparam logic [CSR_ADDR_W-1:0] CSR_INSTRETH      = 12'hC82;
  // Identity, read only
  localparam logic [CSR_ADDR_W-1:0] CSR_MVENDORID     = 12'hF11;
  localparam logic [CSR_ADDR_W-1:0] CSR_MARCHID       = 12'hF12;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIMPID        = 12'hF13;
  localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID       = 12'hF14;

  localparam logic [XLEN-3:0] MTVEC_RST    = 30'h0000_0040;  // Base word, reads 0x100
  localparam logic [XLEN-1:0] MSCRATCH_RST = 32'h0000_0000;

  localparam logic [XLEN-1:0] MISA_DEF      = 32'h4000_1104; // MXL=1, I M C
  localparam logic [XLEN-1:0] MVENDORID_DEF = 32'h0000_0000; // Non-commercial
  localparam logic [XLEN-1:0] MARCHID_DEF   = 32'h0000_0000;
  localparam logic [XLEN-1:0] MIMPID_DEF    = 32'h0000_0001;
  localparam logic [XLEN-1:0] MSTATUS_FIXED = 32'h0000_1800; // MPP stuck at machine

  // One write word, decoded per target register
  typedef union packed {
    logic [XLEN-1:0] raw;                                 // Scratch and counters
    struct packed {
      logic [23:0] rsvd_hi;
      logic        mpie;                                  // Bit 7
      logic [2:0]  rsvd_mid;
      logic        mie;                                   // Bit 3
      logic [2:0]  rsvd_lo;
    } mstatus;
    struct packed {
      logic [MLI_W-1:0] mlie;                             // Local enables 31:16
      logic [3:0]       rsvd_3;
      logic             meie;                             // Bit 11
      logic [2:0]       rsvd_2;
      logic             mtie;                             // Bit 7
      logic [2:0]       rsvd_1;
      logic             msie;                             // Bit 3
      logic [2:0]       rsvd_0;
    } mie;
    struct packed {
      logic [XLEN-3:0] base;                              // Word aligned base
      logic [1:0]      mode;                              // Vector mode
    } mtvec;
    struct packed {
      logic [28:0] rsvd_hi;
      logic        ir;                                    // Instret inhibit, bit 2
      logic        rsvd_tm;                               // Time slot, not inhibitable
      logic        cy;                                    // Cycle inhibit, bit 0
    } mcinh;
  } csr_word_u;

endpackage

`default_nettype wire

// File: csr_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux (
  input  wire [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  wire                           mie_reg,
  input  wire                           mpie_reg,
  input  wire                           meie_reg,
  input  wire                           mtie_reg,
  input  wire                           msie_reg,
  input  wire [csr_pkg::MLI_W-1:0]      mlie_reg,
  input  wire [csr_pkg::XLEN-3:0]       mtvec_reg,
  input  wire [1:0]                     vmode_reg,
  input  wire [csr_pkg::XLEN-1:0]       mscratch_reg,
  input  wire                           cycle_inhibit,
  input  wire                           instret_inhibit,
  input  wire [2*csr_pkg::XLEN-1:0]     cycle_count,
  input  wire [2*csr_pkg::XLEN-1:0]     instret_count,
  input  wire                           meip_reg,
  input  wire                           mtip_reg,
  input  wire                           msip_reg,
  input  wire [csr_pkg::MLI_W-1:0]      mlip_reg,
  input  wire [csr_pkg::HW_ID_W-1:0]    hw_id,
  output logic [csr_pkg::XLEN-1:0]      csr_idata
);
  import csr_pkg::*;

  csr_word_u mstatus_rd, mie_rd, mip_rd, mtvec_rd, mcinh_rd;  // Packed field words

  always_comb begin
    mstatus_rd              = '0;
    mstatus_rd.mstatus.mpie = mpie_reg;
    mstatus_rd.mstatus.mie  = mie_reg;
    mie_rd                  = '0;                         // Same layout as mip
    mie_rd.mie.mlie         = mlie_reg;
    mie_rd.mie.meie         = meie_reg;
    mie_rd.mie.mtie         = mtie_reg;
    mie_rd.mie.msie         = msie_reg;
    mip_rd                  = '0;
    mip_rd.mie.mlie         = mlip_reg;
    mip_rd.mie.meie         = meip_reg;
    mip_rd.mie.mtie         = mtip_reg;
    mip_rd.mie.msie         = msip_reg;
    mtvec_rd.mtvec.base     = mtvec_reg;
    mtvec_rd.mtvec.mode     = vmode_reg;
    mcinh_rd                = '0;
    mcinh_rd.mcinh.ir       = instret_inhibit;
    mcinh_rd.mcinh.cy       = cycle_inhibit;
  end

  always_comb begin
    case (csr_addr)
      CSR_MSTATUS:                csr_idata = mstatus_rd.raw | MSTATUS_FIXED;
      CSR_MISA:                   csr_idata = MISA_DEF;
      CSR_MIE:                    csr_idata = mie_rd.raw;
      CSR_MTVEC:                  csr_idata = mtvec_rd.raw;
      CSR_MSCRATCH:               csr_idata = mscratch_reg;
      CSR_MIP:                    csr_idata = mip_rd.raw;
      CSR_MCOUNTINHIBIT:          csr_idata = mcinh_rd.raw;
      CSR_MCYCLE, CSR_CYCLE:      csr_idata = cycle_count[XLEN-1:0];
      CSR_MCYCLEH, CSR_CYCLEH:    csr_idata = cycle_count[2*XLEN-1:XLEN];
      CSR_MINSTRET, CSR_INSTRET:  csr_idata = instret_count[XLEN-1:0];
      CSR_MINSTRETH, CSR_INSTRETH: csr_idata = instret_count[2*XLEN-1:XLEN];
      CSR_MVENDORID:              csr_idata = MVENDORID_DEF;
      CSR_MARCHID:                csr_idata = MARCHID_DEF;
      CSR_MIMPID:                 csr_idata = MIMPID_DEF;
      CSR_MHARTID:                csr_idata = XLEN'(hw_id);  // Zero extended
      default:                    csr_idata = '0;          // Unimplemented reads 0
    endcase
  end

endmodule

`default_nettype wire

// File: csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
  input  wire                           clk,
  input  wire                           resetb,
  input  wire                           csr_write,
  input  wire [csr_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  wire csr_pkg::csr_word_u       csr_wdata,
  input  wire [csr_pkg::CSR_ADDR_W-1:0] csr_achk,
  input  wire                           iack_int,
  input  wire                           eret_inst,
  input  wire                           inst_ret,
  input  wire                           meip_reg,
  input  wire                           mtip_reg,
  input  wire                           msip_reg,
  input  wire [csr_pkg::MLI_W-1:0]      mlip_reg,
  input  wire [csr_pkg::HW_ID_W-1:0]    hw_id,
  output logic [csr_pkg::XLEN-1:0]      csr_idata,
  output logic                          csr_ok_int,
  output logic                          mie_reg,
  output logic                          meie_reg,
  output logic                          mtie_reg,
  output logic                          msie_reg,
  output logic [csr_pkg::MLI_W-1:0]     mlie_reg,
  output logic [csr_pkg::XLEN-3:0]      mtvec_reg,
  output logic [1:0]                    vmode_reg
);
  import csr_pkg::*;

  logic mstatus_wr, mie_wr, mtvec_wr, mscratch_wr, mcinh_wr;        // Register strobes
  logic mcycle_wr, mcycleh_wr, minstret_wr, minstreth_wr;           // Counter strobes
  logic mpie_reg;                                                   // Stacked enable
  logic cycle_inhibit, instret_inhibit;
  logic [XLEN-1:0]   mscratch_reg;
  logic [2*XLEN-1:0] cycle_count, instret_count;

  csr_decode u_decode (
    .csr_write, .csr_addr, .csr_achk,
    .mstatus_wr, .mie_wr, .mtvec_wr, .mscratch_wr, .mcinh_wr,
    .mcycle_wr, .mcycleh_wr, .minstret_wr, .minstreth_wr, .csr_ok_int
  );

  csr_machine_regs u_machine_regs (
    .clk, .resetb, .mstatus_wr, .mie_wr, .mtvec_wr, .mscratch_wr, .mcinh_wr,
    .iack_int, .eret_inst, .wdata(csr_wdata),
    .mie_reg, .mpie_reg, .meie_reg, .mtie_reg, .msie_reg, .mlie_reg,
    .mtvec_reg, .vmode_reg, .mscratch_reg, .cycle_inhibit, .instret_inhibit
  );

  csr_event_counter cycle_counter (                       // One count per edge
    .clk, .resetb, .count_en(!cycle_inhibit),
    .wr_lo(mcycle_wr), .wr_hi(mcycleh_wr), .wdata(csr_wdata), .count(cycle_count)
  );

  csr_event_counter instret_counter (                     // One count per retire pulse
    .clk, .resetb, .count_en(inst_ret && !instret_inhibit),
    .wr_lo(minstret_wr), .wr_hi(minstreth_wr), .wdata(csr_wdata), .count(instret_count)
  );

  csr_read_mux u_read_mux (
    .csr_addr, .mie_reg, .mpie_reg, .meie_reg, .mtie_reg, .msie_reg, .mlie_reg,
    .mtvec_reg, .vmode_reg, .mscratch_reg, .cycle_inhibit, .instret_inhibit,
    .cycle_count, .instret_count, .meip_reg, .mtip_reg, .msip_reg, .mlip_reg,
    .hw_id, .csr_idata
  );

endmodule

`default_nettype wire

// File: csr_vectors.mem
// test op addr data expect; a write keeps data under the expect mask, random elsewhere
// op 1 write, 2 read, 3 addr check (data = offset bitmap), 4 iack, 5 eret, 6 retire, 7 idle, 8 write+iack, 9 output, A cycle model, B random addr
1 2 300 0 00001880
1 2 305 0 00000100
1 2 304 0 00000000
1 2 340 0 00000000
1 2 344 0 A5C30808
1 2 B02 0 00000000
1 2 B82 0 00000000
1 2 301 0 40001104
1 2 F13 0 00000001
1 2 F14 0 000002B5
1 A B00 0 0
1 9 0 0 0
1 9 5 0 00000100
2 1 304 FFFFFFFF FFFFFFFF
2 2 304 0 FFFF0888
2 9 1 0 1
2 1 305 00002003 FFFFFFFF
2 9 5 0 00002003
2 1 340 DEADBEEF FFFFFFFF
2 2 340 0 DEADBEEF
2 1 300 FFFFFFFF FFFFFFFF
2 2 300 0 00001888
2 2 7B0 0 0
2 2 C01 0 0
3 1 300 00000008 00000088
3 2 300 0 00001808
3 9 0 0 1
3 4 0 0 0
3 2 300 0 00001880
3 9 0 0 0
3 5 0 0 0
3 2 300 0 00001888
3 8 300 00000008 00000088
3 2 300 0 00001808
4 1 320 00000004 00000005
4 1 B02 FFFFFFFF FFFFFFFF
4 1 B82 00000005 FFFFFFFF
4 1 320 00000000 00000005
4 6 0 0 0
4 2 B02 0 00000000
4 2 B82 0 00000006
4 2 C02 0 00000000
4 2 C82 0 00000006
5 1 320 00000001 00000005
5 A B00 0 0
5 1 320 00000000 00000005
5 7 0 A 0
5 1 320 00000001 00000005
5 A B00 0 0
5 A B80 0 0
5 7 0 5 0
5 A C00 0 0
6 3 300 33 1
6 3 302 3 0
6 3 320 1 1
6 3 340 11 1
6 3 B00 5 1
6 3 B80 5 1
6 3 C00 5 1
6 3 C80 5 1
6 3 F11 F 1
6 3 7B0 1 0
6 3 C01 1 0
6 3 341 1 0
6 B 0 0 0
0 0 0 0 0

// File: src.f
csr_pkg.sv
csr_decode.sv
csr_machine_regs.sv
csr_event_counter.sv
csr_read_mux.sv
csr_unit.sv
tb_csr_unit.sv

// File: tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;
  import csr_pkg::*;

  localparam int NVEC     = 128;                          // Vector slots, five words each
  localparam int IDLE_MAX = 1000;                         // Longest idle run allowed

  logic                  clk, resetb, csr_write, iack_int, eret_inst, inst_ret;
  logic [CSR_ADDR_W-1:0] csr_addr, csr_achk;
  csr_word_u             csr_wdata;
  logic                  meip_reg, mtip_reg, msip_reg;
  logic [MLI_W-1:0]      mlip_reg;
  logic [HW_ID_W-1:0]    hw_id;
  logic [XLEN-1:0]       csr_idata;
  logic                  csr_ok_int, mie_reg, meie_reg, mtie_reg, msie_reg;
  logic [MLI_W-1:0]      mlie_reg;
  logic [XLEN-3:0]       mtvec_reg;
  logic [1:0]            vmode_reg;

  logic [31:0] vec_mem [0:5*NVEC-1];                      // test, op, addr, data, expect
  logic [63:0] cyc_model;                                 // Reference cycle count
  logic        cyc_inh_model;
  integer      seed;
  int          vi, checks, errors, test_checks, test_errors, tests_passed, tests_failed;
  logic [7:0]  cur_test;

  csr_unit UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                                // 4 ns period
  end

  always @(posedge clk or negedge resetb) begin           // One count per uninhibited edge
    if (!resetb) begin
      cyc_model     <= '0;
      cyc_inh_model <= 1'b0;
    end else begin
      if (csr_write && csr_addr == CSR_MCOUNTINHIBIT) cyc_inh_model <= csr_wdata.mcinh.cy;
      if (!cyc_inh_model) cyc_model <= cyc_model + 64'd1;  // Old inhibit applies
    end
  end

  function automatic string test_name(input logic [7:0] id);
    case (id)
      8'h1:    return "reset_values";
      8'h2:    return "write_readback";
      8'h3:    return "irq_enable_stack";
      8'h4:    return "instret_carry";
      8'h5:    return "cycle_count";
      8'h6:    return "address_check";
      default: return "unnamed";
    endcase
  endfunction

  task automatic check_word(input csr_word_u exp_w, input csr_word_u act_w);
    checks++;
    test_checks++;
    if (act_w !== exp_w) begin
      errors++;
      test_errors++;
      $display("FAIL %s vector %0d: expected %08h actual %08h",
               test_name(cur_test), vi, exp_w.raw, act_w.raw);
    end
  endtask

  task automatic check_bit(input logic exp_b, input logic act_b);
    checks++;
    test_checks++;
    if (act_b !== exp_b) begin
      errors++;
      test_errors++;
      $display("FAIL %s vector %0d: expected %b actual %b",
               test_name(cur_test), vi, exp_b, act_b);
    end
  endtask

  task automatic compare_enables(input csr_word_u exp_w);  // Expected levels in mie layout
    check_bit(exp_w.mie.meie, meie_reg);
    check_bit(exp_w.mie.mtie, mtie_reg);
    check_bit(exp_w.mie.msie, msie_reg);
    check_word(32'(exp_w.mie.mlie), 32'(mlie_reg));
  endtask

  task automatic finish_test();
    if (test_errors == 0) tests_passed++;
    else tests_failed++;
    $display("test %0d %s: %s, %0d checks, %0d errors", cur_test, test_name(cur_test),
             test_errors == 0 ? "pass" : "fail", test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;                                                   // Drive point after the edge
  endtask

  initial begin
    logic [31:0] op, addr, data, expv, rnd;
    int          b;
    seed      = 32'h2047984b;
    resetb    = 1'b0;
    csr_write = 1'b0;
    csr_addr  = '0;
    csr_achk  = '0;
    csr_wdata = '0;
    iack_int  = 1'b0;
    eret_inst = 1'b0;
    inst_ret  = 1'b0;
    meip_reg  = 1'b1;                                     // Pending levels held constant
    mtip_reg  = 1'b0;
    msip_reg  = 1'b1;
    mlip_reg  = 16'hA5C3;
    hw_id     = 10'h2B5;
    checks       = 0;
    errors       = 0;
    test_checks  = 0;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    $readmemh("csr_vectors.mem", vec_mem);
    repeat (3) @(posedge clk);
    #1 resetb = 1'b1;
    if (vec_mem[1] === 'x) begin
      $display("vector file csr_vectors.mem was not loaded");
      errors++;
    end else begin
      cur_test = vec_mem[0][7:0];
      compare_enables('0);                                // All enables clear out of reset
      for (vi = 0; vi < NVEC; vi++) begin
        b    = 5 * vi;
        op   = vec_mem[b+1];
        addr = vec_mem[b+2];
        data = vec_mem[b+3];
        expv = vec_mem[b+4];
        if (op === 32'h0 || op === 'x) break;             // End marker
        if (vec_mem[b][7:0] != cur_test) begin
          finish_test();
          cur_test = vec_mem[b][7:0];
        end
        csr_addr = addr[CSR_ADDR_W-1:0];
        case (op)
          32'h1, 32'h8: begin                             // Write, random filler outside mask
            rnd            = $random(seed);
            csr_wdata.raw  = (data & expv) | (rnd & ~expv);
            csr_write      = 1'b1;
            iack_int       = (op == 32'h8);
            next_cycle();
            csr_write      = 1'b0;
            iack_int       = 1'b0;
            if (csr_addr == CSR_MIE) compare_enables(csr_wdata);  // Outputs one cycle later
            if (csr_addr == CSR_MCOUNTINHIBIT)            // Only bits 2 and 0 kept
              check_word(csr_wdata.raw & 32'h0000_0005, csr_idata);
          end
          32'h2: begin
            #2 check_word(expv, csr_idata);
            next_cycle();
          end
          32'h3: begin                                    // Data is an offset bitmap
            for (int k = 0; k < 32; k++) begin
              if (data[k]) begin
                csr_achk = CSR_ADDR_W'(addr + 32'(k));
                #2 check_bit(expv[0], csr_ok_int);
                next_cycle();
              end
            end
          end
          32'h4, 32'h5, 32'h6: begin
            iack_int  = (op == 32'h4);
            eret_inst = (op == 32'h5);
            inst_ret  = (op == 32'h6);
            next_cycle();
            iack_int  = 1'b0;
            eret_inst = 1'b0;
            inst_ret  = 1'b0;
          end
          32'h7: begin
            if (data > IDLE_MAX) begin
              $display("idle run of %0d cycles in vector %0d exceeds the limit", data, vi);
              errors++;
              test_errors++;
            end
            for (int n = 0; n < IDLE_MAX && n < int'(data); n++) next_cycle();
          end
          32'h9: begin                                    // Enable and vector outputs
            #2;
            case (addr[2:0])
              3'd0:    check_bit(expv[0], mie_reg);
              3'd1:    check_bit(expv[0], meie_reg);
              3'd2:    check_bit(expv[0], mtie_reg);
              3'd3:    check_bit(expv[0], msie_reg);
              3'd4:    check_word(expv, 32'(mlie_reg));
              default: check_word(expv, {mtvec_reg, vmode_reg});
            endcase
            next_cycle();
          end
          32'hA: begin                                    // Bit 7 picks the high half
            #2 check_word(addr[7] ? cyc_model[63:32] : cyc_model[31:0], csr_idata);
            next_cycle();
          end
          32'hB: begin                                    // Custom range, never implemented
            rnd      = $random(seed);
            csr_achk = {6'h1F, rnd[5:0]};
            #2 check_bit(1'b0, csr_ok_int);
            next_cycle();
          end
          default: begin
            $display("unknown opcode %0h in vector %0d", op, vi);
            errors++;
            test_errors++;
          end
        endcase
      end
      finish_test();
    end
    $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
